// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/rv_alu.sv
  - logic/rv_regfile.sv
  - logic/rv_forward.sv
  - logic/rv_decoder.sv
  - logic/rv_fetch.sv
  - logic/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_assert.sv
      - sim/tb_rv_core.sv

// ==== logic/rv_alu.sv ====
// Combinational ALU for add, sub, logic, shift and signed compare
`timescale 1ns/1ps

module rv_alu
    import rv_pkg::*;
(
    input  alu_op_e         alu_op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = $unsigned($signed(a) >>> shamt); // Sign fill
            ALU_SLT: result = XLEN'($signed(a) < $signed(b));
            default: result = '0;
        endcase
    end

endmodule

// ==== logic/rv_core.sv ====
// Five-stage RV32I core top with stage instances and later pipeline registers
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic [XLEN-3:0] imem_addr,
    input  logic [XLEN-1:0] imem_rdata,
    output logic            dmem_ren,
    output logic            dmem_wen,
    output logic [XLEN-3:0] dmem_addr,
    output logic [XLEN-1:0] dmem_wdata,
    input  logic [XLEN-1:0] dmem_rdata,
    output logic [XLEN-1:0] pc
);

    logic [XLEN-1:0]       if_pc, if_instr, target, imm, rs1_data, rs2_data, br_rs1, br_rs2;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    alu_op_e               alu_op;
    logic                  alu_src, reg_write, mem_read, mem_write, is_branch, is_jal;
    logic                  redirect, stall;
    logic [1:0]            br_sel1, br_sel2, alu_sel1, alu_sel2;

    // Decode/execute
    logic [REG_ADDR_W-1:0] de_rs1_addr, de_rs2_addr, de_rd;
    logic [XLEN-1:0]       de_rs1_data, de_rs2_data, de_imm;
    alu_op_e               de_alu_op;
    logic                  de_alu_src, de_reg_write, de_mem_read, de_mem_write;
    logic [XLEN-1:0]       alu_a, alu_b, rs2_fwd, alu_result;

    // Execute/memory and memory/writeback
    logic [REG_ADDR_W-1:0] em_rd, mw_rd;
    logic                  em_reg_write, em_mem_read, em_mem_write, mw_reg_write, mw_mem_read;
    logic [XLEN-1:0]       em_alu, em_store_data, mw_alu, mw_load_data, wb_data;

    rv_fetch #(.RESET_PC(RESET_PC)) fetch0 (
        .clk, .rst_n, .stall, .redirect, .target, .imem_rdata, .pc, .if_pc, .if_instr
    );

    rv_decoder decoder0 (
        .if_instr, .if_pc, .br_rs1, .br_rs2, .rs1_addr, .rs2_addr, .rd_addr, .imm, .alu_op,
        .alu_src, .reg_write, .mem_read, .mem_write, .is_branch, .is_jal, .redirect, .target
    );

    rv_regfile regfile0 (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .wr_addr(mw_rd), .wr_en(mw_reg_write),
        .wr_data(wb_data), .rs1_data, .rs2_data
    );

    rv_forward forward0 (
        .rs1_addr, .rs2_addr, .is_branch,
        .ex_rs1_addr(de_rs1_addr), .ex_rs2_addr(de_rs2_addr), .ex_rd(de_rd),
        .ex_reg_write(de_reg_write), .ex_mem_read(de_mem_read),
        .mem_rd(em_rd), .mem_reg_write(em_reg_write), .mem_mem_read(em_mem_read),
        .wb_rd(mw_rd), .wb_reg_write(mw_reg_write),
        .stall, .br_sel1, .br_sel2, .alu_sel1, .alu_sel2
    );

    rv_alu alu0 (.alu_op(de_alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

    assign imem_addr = pc[XLEN-1:2];

    // Comparator operands, execute result is youngest
    assign br_rs1 = (br_sel1 == 2'd3) ? alu_result :
                    (br_sel1 == 2'd2) ? em_alu     :
                    (br_sel1 == 2'd1) ? wb_data    : rs1_data;
    assign br_rs2 = (br_sel2 == 2'd3) ? alu_result :
                    (br_sel2 == 2'd2) ? em_alu     :
                    (br_sel2 == 2'd1) ? wb_data    : rs2_data;

    // Stall drops a bubble into execute
    always_ff @(posedge clk) begin
        if (!rst_n || stall) begin
            de_rs1_addr  <= '0;
            de_rs2_addr  <= '0;
            de_rd        <= '0;
            de_alu_op    <= ALU_AND;
            de_alu_src   <= 1'b0;
            de_reg_write <= 1'b0;
            de_mem_read  <= 1'b0;
            de_mem_write <= 1'b0;
        end else begin
            de_rs1_addr  <= rs1_addr;
            de_rs2_addr  <= rs2_addr;
            de_rd        <= rd_addr;
            de_alu_op    <= alu_op;
            de_alu_src   <= alu_src;
            de_reg_write <= reg_write;
            de_mem_read  <= mem_read;
            de_mem_write <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        de_rs1_data <= is_jal ? if_pc : rs1_data;          // JAL links pc plus four
        de_rs2_data <= is_jal ? XLEN'(4) : rs2_data;
        de_imm      <= imm;
    end

    assign alu_a   = (alu_sel1 == 2'd2) ? em_alu  :
                     (alu_sel1 == 2'd1) ? wb_data : de_rs1_data;
    assign rs2_fwd = (alu_sel2 == 2'd2) ? em_alu  :
                     (alu_sel2 == 2'd1) ? wb_data : de_rs2_data;
    assign alu_b   = de_alu_src ? de_imm : rs2_fwd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            em_rd        <= '0;
            em_reg_write <= 1'b0;
            em_mem_read  <= 1'b0;
            em_mem_write <= 1'b0;
            mw_rd        <= '0;
            mw_reg_write <= 1'b0;
            mw_mem_read  <= 1'b0;
        end else begin
            em_rd        <= de_rd;
            em_reg_write <= de_reg_write;
            em_mem_read  <= de_mem_read;
            em_mem_write <= de_mem_write;
            mw_rd        <= em_rd;
            mw_reg_write <= em_reg_write;
            mw_mem_read  <= em_mem_read;
        end
    end

    always_ff @(posedge clk) begin
        em_alu        <= alu_result;
        em_store_data <= rs2_fwd; // Store data after forwarding
        mw_alu        <= em_alu;
        mw_load_data  <= dmem_rdata;
    end

    assign dmem_ren   = em_mem_read;
    assign dmem_wen   = em_mem_write;
    assign dmem_addr  = em_alu[XLEN-1:2];
    assign dmem_wdata = em_store_data;

    assign wb_data = mw_mem_read ? mw_load_data : mw_alu;

endmodule

// ==== logic/rv_decoder.sv ====
// Instruction decoder with immediates, control flags, branch compare and target
`timescale 1ns/1ps

module rv_decoder
    import rv_pkg::*;
(
    input  logic [XLEN-1:0]       if_instr,
    input  logic [XLEN-1:0]       if_pc,
    input  logic [XLEN-1:0]       br_rs1,
    input  logic [XLEN-1:0]       br_rs2,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [XLEN-1:0]       imm,
    output alu_op_e               alu_op,
    output logic                  alu_src,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  is_branch,
    output logic                  is_jal,
    output logic                  redirect,
    output logic [XLEN-1:0]       target
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
    logic            br_eq;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD; // SLTU not supported
        endcase
    endfunction

    assign opcode = opcode_e'(if_instr[6:0]);
    assign funct3 = if_instr[14:12];

    assign imm_i = {{(XLEN-12){if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{(XLEN-12){if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{(XLEN-13){if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};
    assign imm_j = {{(XLEN-21){if_instr[31]}}, if_instr[31], if_instr[19:12],
                    if_instr[20], if_instr[30:21], 1'b0};

    always_comb begin
        imm       = '0;
        alu_op    = ALU_AND;
        alu_src   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        case (opcode)
            OPC_OP: begin
                reg_write = 1'b1;
                alu_op    = arith_op(funct3, if_instr[30]);
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_i; // Shift amount sits in the low five bits
                alu_op    = arith_op(funct3, if_instr[30] && funct3 == 3'b101);
            end
            OPC_LOAD: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                mem_read  = 1'b1;
                imm       = imm_i;
                alu_op    = ALU_ADD;
            end
            OPC_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                imm       = imm_s;
                alu_op    = ALU_ADD;
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                imm       = imm_b;
            end
            OPC_JAL: begin
                is_jal    = 1'b1;
                reg_write = 1'b1;
                imm       = imm_j;
                alu_op    = ALU_ADD; // Link value is pc plus four
            end
            default: ;
        endcase
    end

    // JAL reads no registers
    assign rs1_addr = is_jal ? '0 : if_instr[19:15];
    assign rs2_addr = is_jal ? '0 : if_instr[24:20];
    assign rd_addr  = if_instr[11:7];

    assign br_eq    = (br_rs1 == br_rs2);
    assign redirect = is_jal || (is_branch && (br_eq != funct3[0])); // funct3[0] marks BNE
    assign target   = if_pc + imm;

endmodule

// ==== logic/rv_fetch.sv ====
// Program counter and fetch/decode pipeline register
`timescale 1ns/1ps

module rv_fetch
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            redirect,
    input  logic [XLEN-1:0] target,
    input  logic [XLEN-1:0] imem_rdata,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] if_pc,
    output logic [XLEN-1:0] if_instr
);

    // Stall wins over redirect, a stalled branch has stale operands
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            if_pc    <= RESET_PC;
            if_instr <= NOP_INSTR;
        end else if (!stall) begin
            if_pc <= pc;
            if (redirect) begin
                pc       <= target;
                if_instr <= NOP_INSTR; // Squash the slot behind the jump
            end else begin
                pc       <= pc + XLEN'(4);
                if_instr <= imem_rdata;
            end
        end
    end

endmodule

// ==== logic/rv_forward.sv ====
// Hazard detection and forwarding select generation for decode and execute
`timescale 1ns/1ps

module rv_forward
    import rv_pkg::*;
(
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic                  is_branch,
    input  logic [REG_ADDR_W-1:0] ex_rs1_addr,
    input  logic [REG_ADDR_W-1:0] ex_rs2_addr,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_read,
    input  logic [REG_ADDR_W-1:0] mem_rd,
    input  logic                  mem_reg_write,
    input  logic                  mem_mem_read,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic                  wb_reg_write,
    output logic                  stall,
    output logic [1:0]            br_sel1,
    output logic [1:0]            br_sel2,
    output logic [1:0]            alu_sel1,
    output logic [1:0]            alu_sel2
);

    logic load_use, branch_load;

    function automatic logic hit(input logic [REG_ADDR_W-1:0] rd, input logic we,
                                 input logic [REG_ADDR_W-1:0] rs);
        return we && (rd != '0) && (rd == rs);
    endfunction

    // Branch operand from execute (3), memory (2), writeback (1) or register file (0)
    function automatic logic [1:0] br_pick(input logic [REG_ADDR_W-1:0] rs);
        if (hit(ex_rd, ex_reg_write, rs))   return 2'd3;
        if (hit(mem_rd, mem_reg_write, rs)) return 2'd2;
        if (hit(wb_rd, wb_reg_write, rs))   return 2'd1;
        return 2'd0;
    endfunction

    // ALU operand from memory (2), writeback (1) or the decode/execute register (0)
    function automatic logic [1:0] alu_pick(input logic [REG_ADDR_W-1:0] rs);
        if (hit(mem_rd, mem_reg_write, rs)) return 2'd2;
        if (hit(wb_rd, wb_reg_write, rs))   return 2'd1;
        return 2'd0;
    endfunction

    assign load_use    = hit(ex_rd, ex_mem_read, rs1_addr) || hit(ex_rd, ex_mem_read, rs2_addr);
    assign branch_load = is_branch &&
                         (hit(mem_rd, mem_mem_read, rs1_addr) ||
                          hit(mem_rd, mem_mem_read, rs2_addr)); // Load data not back yet
    assign stall       = load_use || branch_load;

    always_comb begin
        br_sel1  = br_pick(rs1_addr);
        br_sel2  = br_pick(rs2_addr);
        alu_sel1 = alu_pick(ex_rs1_addr);
        alu_sel2 = alu_pick(ex_rs2_addr);
    end

endmodule

// ==== logic/rv_pkg.sv ====
// Shared widths, NOP encoding, opcode and ALU operation enums for the RV32I core
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // Major opcodes, anything else decodes as a NOP
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // R-type ALU
        OPC_OP_IMM = 7'b0010011, // I-type ALU and shifts
        OPC_LOAD   = 7'b0000011, // LW
        OPC_STORE  = 7'b0100011, // SW
        OPC_BRANCH = 7'b1100011, // BEQ, BNE
        OPC_JAL    = 7'b1101111  // JAL
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2, // Carried by bubbles
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SRA = 4'd7,
        ALU_SLT = 4'd8
    } alu_op_e;

endpackage

// ==== logic/rv_regfile.sv ====
// Register file, two read ports with write bypass, one write port, x0 fixed at zero
`timescale 1ns/1ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [REG_ADDR_W-1:0] wr_addr,
    input  logic                  wr_en,
    input  logic [XLEN-1:0]       wr_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_live;

    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle writeback reaches decode through the bypass
    assign rs1_data = (wr_live && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (wr_live && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

// ==== sim/rv_core_assert.sv ====
// Concurrent assertions on rv_core data strobes and PC, with the bind to rv_core
`timescale 1ns/1ps

module rv_core_assert
    import rv_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input logic            clk,
    input logic            rst_n,
    input logic            dmem_ren,
    input logic            dmem_wen,
    input logic [XLEN-1:0] pc
);

    int fails = 0; // Read by the testbench

    // One data access per cycle at most
    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_ren && dmem_wen))
        else begin
            $error("dmem_ren and dmem_wen high in the same cycle");
            fails++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else begin
            $error("pc %h is not word aligned", pc);
            fails++;
        end

    // First cycle out of reset
    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (pc == RESET_PC) && !dmem_ren && !dmem_wen)
        else begin
            $error("pc or data strobes wrong in the first cycle after reset");
            fails++;
        end

endmodule

bind rv_core rv_core_assert #(.RESET_PC(RESET_PC)) assert0 (
    .clk(clk), .rst_n(rst_n), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .pc(pc)
);

// ==== sim/tb_rv_core.sv ====
// Testbench for rv_core with memories, instruction encoders, program table, checker and watchdog
`timescale 1ns/1ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam int              CLK_PERIOD = 40;
    localparam int              SEED       = 21153;
    localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0100;
    localparam int              F_ADD      = 0;
    localparam int              F_SLL      = 1;
    localparam int              F_SLT      = 2;
    localparam int              F_XOR      = 4;
    localparam int              F_SR       = 5; // SRL, SRA with alt set
    localparam int              F_OR       = 6;
    localparam int              F_AND      = 7;

    logic            clk, rst_n;
    logic [XLEN-3:0] imem_addr, dmem_addr;
    logic [XLEN-1:0] imem_rdata, dmem_rdata, dmem_wdata, pc;
    logic            dmem_ren, dmem_wen;
    logic [XLEN-1:0] imem [64];
    logic [XLEN-1:0] dmem [64];

    // Test table, programs and expected stores kept flat
    string           t_name[$];
    int              t_start[$], t_len[$], t_budget[$], t_exp_start[$], t_exp_len[$];
    logic [XLEN-1:0] prog[$], exp_addr[$], exp_data[$];
    logic [XLEN-1:0] got_addr[$], got_data[$];
    bit              table_ready = 1'b0;
    int              errors = 0;
    int              passed = 0;

    rv_core #(.RESET_PC(RESET_PC)) dut0 (
        .clk, .rst_n, .imem_addr, .imem_rdata, .dmem_ren, .dmem_wen, .dmem_addr,
        .dmem_wdata, .dmem_rdata, .pc
    );

    assign imem_rdata = imem[imem_addr[5:0]]; // Same-cycle answers
    assign dmem_rdata = dmem_ren ? dmem[dmem_addr[5:0]] : '0; // Data only on a load strobe

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Store strobe is stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && dmem_wen) begin
            dmem[dmem_addr[5:0]] = dmem_wdata;
            got_addr.push_back(XLEN'(dmem_addr));
            got_data.push_back(dmem_wdata);
        end
    end

    function automatic logic [31:0] arith(input int f3, input int alt, input int rd,
                                          input int rs1, input int rs2);
        return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] arith_imm(input int f3, input int rd, input int rs1,
                                              input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] load_word(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input int bne, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, bne[0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jump(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic new_test(input string name, input int budget);
        t_name.push_back(name);
        t_budget.push_back(budget);
        t_start.push_back(prog.size());
        t_len.push_back(0);
        t_exp_start.push_back(exp_addr.size());
        t_exp_len.push_back(0);
    endtask

    task automatic emit(input logic [31:0] instr);
        prog.push_back(instr);
        t_len[t_len.size()-1] += 1;
    endtask

    task automatic store_expect(input int rs2, input int byte_addr, input logic [31:0] value);
        emit(store_word(rs2, 0, byte_addr));
        exp_addr.push_back(32'(byte_addr >> 2));
        exp_data.push_back(value);
        t_exp_len[t_exp_len.size()-1] += 1;
    endtask

    // Operation writes x4 and a store of x4 follows
    task automatic result_store(input logic [31:0] instr, input int byte_addr,
                                input logic [31:0] value);
        emit(instr);
        store_expect(4, byte_addr, value);
    endtask

    task automatic build_table();
        int sum;
        int r;
        new_test("alu_ops", 90); // x1 = -1000, x2 = 300, x3 = 37 (shift by 5)
        emit(arith_imm(F_ADD, 1, 0, -1000));
        emit(arith_imm(F_ADD, 2, 0, 300));
        emit(arith_imm(F_ADD, 3, 0, 37));
        result_store(arith(F_ADD, 0, 4, 1, 2), 0, 32'(-700));
        result_store(arith(F_ADD, 1, 4, 1, 2), 4, 32'(-1300));
        result_store(arith(F_AND, 0, 4, 1, 2), 8, 32'(-1000) & 32'd300);
        result_store(arith(F_OR, 0, 4, 1, 2), 12, 32'(-1000) | 32'd300);
        result_store(arith(F_XOR, 0, 4, 1, 2), 16, 32'(-1000) ^ 32'd300);
        result_store(arith(F_SLL, 0, 4, 1, 3), 20, 32'hffff_8300);
        result_store(arith(F_SR, 0, 4, 1, 3), 24, 32'h07ff_ffe0);
        result_store(arith(F_SR, 1, 4, 1, 3), 28, 32'hffff_ffe0); // Rounds toward minus
        result_store(arith(F_SLT, 0, 4, 1, 2), 32, 32'd1);
        result_store(arith(F_SLT, 0, 4, 2, 1), 36, 32'd0);
        result_store(arith_imm(F_ADD, 4, 1, 1500), 40, 32'd500);
        result_store(arith_imm(F_AND, 4, 1, 32'h7f0), 44, 32'h0000_0410);
        result_store(arith_imm(F_OR, 4, 2, -16), 48, 32'hffff_fffc);
        result_store(arith_imm(F_XOR, 4, 1, -1), 52, 32'd999);
        result_store(arith_imm(F_SLT, 4, 1, -999), 56, 32'd1);
        result_store(arith_imm(F_SLL, 4, 2, 3), 60, 32'd2400);
        result_store(arith_imm(F_SR, 4, 1, 28), 64, 32'h0000_000f);
        result_store(arith_imm(F_SR, 4, 1, 32'h400 | 8), 68, 32'hffff_fffc); // SRAI
        emit(jump(0, 0));

        new_test("fwd_chain", 40);
        sum = 0;
        for (int i = 0; i < 8; i++) begin
            r = int'($urandom() % 4096) - 2048; // Signed 12-bit immediate
            sum += r;
            emit(arith_imm(F_ADD, 5, (i == 0) ? 0 : 5, r));
        end
        store_expect(5, 100, 32'(sum));
        emit(jump(0, 0));

        new_test("load_use", 40);
        emit(arith_imm(F_ADD, 1, 0, 32'h123));
        emit(arith_imm(F_ADD, 3, 0, 32'h45));
        store_expect(1, 120, 32'h123);
        emit(load_word(2, 0, 120));
        emit(arith(F_ADD, 0, 4, 2, 3)); // Needs the load result at once
        store_expect(4, 124, 32'h168);
        emit(load_word(5, 0, 124));
        store_expect(5, 128, 32'h168);
        emit(jump(0, 0));

        new_test("branches", 60);
        emit(arith_imm(F_ADD, 1, 0, 5));
        emit(arith_imm(F_ADD, 2, 0, 5));
        emit(branch(0, 1, 2, 12)); // BEQ taken
        emit(store_word(1, 0, 140)); // Squashed slot
        emit(store_word(1, 0, 144));
        emit(arith_imm(F_ADD, 3, 0, 9));
        emit(branch(1, 1, 2, 8)); // BNE not taken
        store_expect(3, 148, 32'd9);
        emit(load_word(4, 0, 148));
        emit(branch(0, 4, 3, 8)); // Compares a value still being loaded
        emit(store_word(4, 0, 156));
        emit(arith_imm(F_ADD, 6, 0, 1));
        emit(branch(1, 6, 0, 8)); // x6 comes from execute
        emit(store_word(6, 0, 160));
        store_expect(6, 164, 32'd1);
        emit(jump(0, 0));

        new_test("jal_link", 30);
        emit(arith_imm(F_ADD, 1, 0, 3));
        emit(arith_imm(F_ADD, 2, 0, 4));
        emit(jump(5, 8)); // At RESET_PC + 8
        emit(store_word(1, 0, 180));
        store_expect(5, 184, RESET_PC + 32'd12);
        emit(arith(F_ADD, 0, 6, 5, 2));
        store_expect(6, 188, RESET_PC + 32'd16);
        emit(jump(0, 0));
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_memories(input int t);
        int base;
        base = RESET_PC[7:2];
        for (int i = 0; i < 64; i++) begin
            imem[i] = arith_imm(F_ADD, 0, 0, i); // NOP carrying its index
            dmem[i] = 32'ha5a5_0000 + i;
        end
        for (int j = 0; j < t_len[t]; j++) begin
            imem[(base + j) % 64] = prog[t_start[t] + j];
        end
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int cycles;
        errs_before = errors;
        @(negedge clk);
        rst_n = 1'b0;
        @(posedge clk); // Strobes cleared here
        @(negedge clk);
        load_memories(t);
        got_addr.delete();
        got_data.delete();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        cycles = 0;
        while (got_data.size() < t_exp_len[t] && cycles < t_budget[t]) begin
            @(posedge clk);
            cycles++;
        end
        if (got_data.size() != t_exp_len[t]) begin
            $display("test %s saw %0d stores where %0d were expected within %0d cycles",
                     t_name[t], got_data.size(), t_exp_len[t], t_budget[t]);
            errors++;
        end
        for (int i = 0; i < got_data.size() && i < t_exp_len[t]; i++) begin
            check($sformatf("dmem_addr[%0d]", i), exp_addr[t_exp_start[t] + i], got_addr[i]);
            check($sformatf("dmem_wdata[%0d]", i), exp_data[t_exp_start[t] + i], got_data[i]);
        end
        if (errors == errs_before) begin
            passed++;
        end
        $display("test %0d %s: %s after %0d cycles", t, t_name[t],
                 (errors == errs_before) ? "pass" : "FAIL", cycles);
    endtask

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0000_0013;
            dmem[i] = '0;
        end
        void'($urandom(SEED));
        build_table();
        table_ready = 1'b1;
        for (int t = 0; t < t_name.size(); t++) begin
            run_test(t);
        end
        if (dut0.assert0.fails != 0) begin
            $display("%0d assertion failures reported", dut0.assert0.fails);
            errors += dut0.assert0.fails;
        end
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d", t_name.size(), passed,
                 t_name.size() - passed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Budget of every test plus reset and setup cycles
    initial begin
        int total;
        wait (table_ready);
        total = 20;
        for (int t = 0; t < t_budget.size(); t++) begin
            total += t_budget[t] + 8;
        end
        #(total * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", total);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_forward.sv
logic/rv_decoder.sv
logic/rv_fetch.sv
logic/rv_core.sv
sim/rv_core_assert.sv
sim/tb_rv_core.sv
